// ==== all.f ====
design/rv_pkg.sv
design/alu.sv
design/alu_decoder.sv
design/imm_extend.sv
design/main_decoder.sv
design/reg_file.sv
design/load_store_unit.sv
design/rv_core.sv
tb/rv_core_checker.sv
tb/tb_rv_core.sv

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [rv_pkg::XLEN-1:0]  a_i,
    input  logic [rv_pkg::XLEN-1:0]  b_i,
    input  rv_pkg::alu_ctrl_e        ctrl_i,
    output logic [rv_pkg::XLEN-1:0]  y_o,
    output logic                     eq_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] diff;
    logic            lt;

    assign diff = a_i - b_i;
    assign eq_o = (diff == '0);                 // Zero difference means equal

    // Signed less-than from the sign bits and the difference
    assign lt = (a_i[XLEN-1] != b_i[XLEN-1]) ? a_i[XLEN-1] : diff[XLEN-1];

    always_comb
    begin
        case (ctrl_i)
            alu_add:    y_o = a_i + b_i;
            alu_sub:    y_o = diff;
            alu_and:    y_o = a_i & b_i;
            alu_or:     y_o = a_i | b_i;
            alu_xor:    y_o = a_i ^ b_i;
            alu_slt:    y_o = {{(XLEN-1){1'b0}}, lt};
            alu_pass_b: y_o = b_i;              // LUI
            default:    y_o = '0;
        endcase
    end

endmodule

// ==== design/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder (
    input  rv_pkg::alu_op_e    alu_op_i,
    input  logic [2:0]         funct3_i,
    input  logic               funct7b5_i,
    input  logic               op_b5_i,         // Set for R-type
    output rv_pkg::alu_ctrl_e  alu_ctrl_o
);
    import rv_pkg::*;

    always_comb
    begin
        case (alu_op_i)
            aluop_add:    alu_ctrl_o = alu_add;
            aluop_branch: alu_ctrl_o = alu_sub;  // Equality through subtraction
            aluop_pass_b: alu_ctrl_o = alu_pass_b;
            default:
            begin
                case (funct3_i)
                    3'b000:  alu_ctrl_o = (op_b5_i && funct7b5_i) ? alu_sub : alu_add;
                    3'b010:  alu_ctrl_o = alu_slt;
                    3'b100:  alu_ctrl_o = alu_xor;
                    3'b110:  alu_ctrl_o = alu_or;
                    3'b111:  alu_ctrl_o = alu_and;
                    default: alu_ctrl_o = alu_add;  // Shifts and SLTU not built
                endcase
            end
        endcase
    end

endmodule

// ==== design/imm_extend.sv ====
`timescale 1ns/1ps

module imm_extend (
    input  logic [31:7]              instr_i,
    input  rv_pkg::imm_type_e        imm_src_i,
    output logic [rv_pkg::XLEN-1:0]  imm_o
);
    import rv_pkg::*;

    always_comb
    begin
        case (imm_src_i)
            imm_itype: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            imm_stype: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            imm_btype: imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                instr_i[11:8], 1'b0};
            imm_jtype: imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                instr_i[30:21], 1'b0};
            imm_utype: imm_o = {instr_i[31:12], 12'b0};          // Upper 20 bits
            default:   imm_o = '0;
        endcase
    end

endmodule

// ==== design/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
    input  logic [rv_pkg::XLEN-1:0]  addr_i,
    input  logic [rv_pkg::XLEN-1:0]  store_data_i,
    input  logic [rv_pkg::XLEN-1:0]  mem_rdata_i,
    input  logic                     mem_type_i,     // 0 word, 1 byte
    input  logic                     mem_sign_i,
    input  logic                     mem_write_i,
    output logic [rv_pkg::XLEN-1:0]  mem_wdata_o,
    output logic [rv_pkg::XLEN-1:0]  load_data_o,
    output logic [3:0]               mem_wstrb_o
);
    import rv_pkg::*;

    logic [7:0] ld_byte;

    always_comb
    begin
        if (mem_type_i)
        begin
            mem_wdata_o = {4{store_data_i[7:0]}};        // Byte on every lane
            mem_wstrb_o = mem_write_i ? (4'b0001 << addr_i[1:0]) : 4'b0000;
        end
        else
        begin
            mem_wdata_o = store_data_i;
            mem_wstrb_o = mem_write_i ? 4'b1111 : 4'b0000;
        end
    end

    assign ld_byte = mem_rdata_i[{addr_i[1:0], 3'b000} +: 8];   // Lane picked by address

    always_comb
    begin
        if (mem_type_i)
            load_data_o = {{(XLEN-8){mem_sign_i & ld_byte[7]}}, ld_byte};
        else
            load_data_o = mem_rdata_i;
    end

endmodule

// ==== design/main_decoder.sv ====
`timescale 1ns/1ps

module main_decoder (
    input  logic                 eq_i,          // Operands equal
    input  logic [6:0]           op_i,          // Instruction opcode
    input  logic [2:0]           funct3_i,
    output logic                 pc_src_o,      // Take PC+imm
    output logic                 mem_write_o,
    output logic                 alu_src_o,     // Immediate as operand B
    output logic                 alu_a_pc_o,    // PC as operand A
    output logic                 reg_write_o,
    output logic                 jalr_pc_src_o, // Jump to ALU result
    output logic                 mem_type_o,    // 0 word, 1 byte
    output logic                 mem_sign_o,    // 0 unsigned, 1 signed
    output rv_pkg::imm_type_e    imm_src_o,
    output rv_pkg::alu_op_e      alu_op_o,
    output rv_pkg::result_sel_e  result_src_o
);
    import rv_pkg::*;

    logic branch;
    logic jal;

    always_comb
    begin
        // Defaults describe a no-op
        reg_write_o   = 1'b0;
        imm_src_o     = imm_itype;
        alu_src_o     = 1'b0;
        alu_a_pc_o    = 1'b0;
        mem_write_o   = 1'b0;
        result_src_o  = res_alu;
        alu_op_o      = aluop_add;
        jalr_pc_src_o = 1'b0;
        mem_type_o    = 1'b0;
        mem_sign_o    = 1'b1;
        branch        = 1'b0;
        jal           = 1'b0;
        case (op_i)
            opc_load:
            begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = res_mem;
                mem_type_o   = (funct3_i[1:0] == 2'b00); // LB and LBU
                mem_sign_o   = ~funct3_i[2];             // LBU is zero-extended
            end
            opc_store:
            begin
                imm_src_o   = imm_stype;
                alu_src_o   = 1'b1;
                mem_write_o = 1'b1;
                mem_type_o  = (funct3_i == 3'b000);      // SB
                mem_sign_o  = 1'b0;
            end
            opc_op:
            begin
                reg_write_o = 1'b1;
                alu_op_o    = aluop_arith;
            end
            opc_op_imm:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = aluop_arith;
            end
            opc_branch:
            begin
                imm_src_o = imm_btype;
                alu_op_o  = aluop_branch;
                branch    = 1'b1;
            end
            opc_jal:
            begin
                reg_write_o  = 1'b1;
                imm_src_o    = imm_jtype;
                result_src_o = res_pc_plus4;
                jal          = 1'b1;
            end
            opc_jalr:
            begin
                reg_write_o   = 1'b1;
                alu_src_o     = 1'b1;                    // rs1 + imm is the target
                result_src_o  = res_pc_plus4;
                jalr_pc_src_o = 1'b1;
            end
            opc_auipc:
            begin
                reg_write_o  = 1'b1;
                imm_src_o    = imm_utype;
                alu_src_o    = 1'b1;
                alu_a_pc_o   = 1'b1;
                result_src_o = res_pc_plus_imm;
            end
            opc_lui:
            begin
                reg_write_o = 1'b1;
                imm_src_o   = imm_utype;
                alu_src_o   = 1'b1;
                alu_op_o    = aluop_pass_b;
            end
            default:
            begin
                reg_write_o = 1'b0;                      // Unknown opcode retires silently
            end
        endcase
    end

    always_comb
    begin
        if (jal)
            pc_src_o = 1'b1;
        else if (branch && funct3_i == 3'b000)
            pc_src_o = eq_i;                             // BEQ
        else if (branch && funct3_i == 3'b001)
            pc_src_o = ~eq_i;                            // BNE
        else
            pc_src_o = 1'b0;
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       we_i,
    input  logic [rv_pkg::REG_AW-1:0]  ra1_i,
    input  logic [rv_pkg::REG_AW-1:0]  ra2_i,
    input  logic [rv_pkg::REG_AW-1:0]  wa_i,
    input  logic [rv_pkg::XLEN-1:0]    wd_i,
    output logic [rv_pkg::XLEN-1:0]    rd1_o,
    output logic [rv_pkg::XLEN-1:0]    rd2_o
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we_i && wa_i != '0 && wa_i < NUM_REGS)
        begin
            regs[wa_i[IDX_W-1:0]] <= wd_i;
        end
    end

    // x0 and registers beyond a reduced file read as zero
    assign rd1_o = (ra1_i != '0 && ra1_i < NUM_REGS) ? regs[ra1_i[IDX_W-1:0]] : '0;
    assign rd2_o = (ra2_i != '0 && ra2_i < NUM_REGS) ? regs[ra2_i[IDX_W-1:0]] : '0;

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter int                      NUM_REGS = 32,
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    output logic [rv_pkg::XLEN-1:0]    imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0]    imem_data_i,
    output logic [rv_pkg::XLEN-1:0]    dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0]    dmem_wdata_o,
    output logic [3:0]                 dmem_wstrb_o,
    output logic                       dmem_we_o,
    input  logic [rv_pkg::XLEN-1:0]    dmem_rdata_i,
    output logic                       wb_valid_o,
    output logic [rv_pkg::REG_AW-1:0]  wb_addr_o,
    output logic [rv_pkg::XLEN-1:0]    wb_data_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc, pc_next, pc_plus4, pc_plus_imm;
    logic            run;                        // Low until first edge after reset
    logic            pc_src, mem_write, alu_src, alu_a_pc, reg_write;
    logic            jalr_pc_src, mem_type, mem_sign, eq;
    imm_type_e       imm_src;
    alu_op_e         alu_op;
    alu_ctrl_e       alu_ctrl;
    result_sel_e     result_src;
    logic [XLEN-1:0] imm, rd1, rd2, src_a, src_b, alu_y, load_data, result;
    logic            reg_we;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            pc  <= RESET_PC;
            run <= 1'b0;
        end
        else
        begin
            run <= 1'b1;
            if (run)
                pc <= pc_next;
        end
    end

    main_decoder i_main_decoder (
        .eq_i(eq), .op_i(imem_data_i[6:0]), .funct3_i(imem_data_i[14:12]),
        .pc_src_o(pc_src), .mem_write_o(mem_write), .alu_src_o(alu_src),
        .alu_a_pc_o(alu_a_pc), .reg_write_o(reg_write), .jalr_pc_src_o(jalr_pc_src),
        .mem_type_o(mem_type), .mem_sign_o(mem_sign), .imm_src_o(imm_src),
        .alu_op_o(alu_op), .result_src_o(result_src)
    );

    alu_decoder i_alu_decoder (
        .alu_op_i(alu_op), .funct3_i(imem_data_i[14:12]), .funct7b5_i(imem_data_i[30]),
        .op_b5_i(imem_data_i[5]), .alu_ctrl_o(alu_ctrl)
    );

    imm_extend i_imm_extend (.instr_i(imem_data_i[31:7]), .imm_src_i(imm_src), .imm_o(imm));

    reg_file #(.NUM_REGS(NUM_REGS)) i_reg_file (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .we_i(reg_we),
        .ra1_i(imem_data_i[19:15]), .ra2_i(imem_data_i[24:20]), .wa_i(imem_data_i[11:7]),
        .wd_i(result), .rd1_o(rd1), .rd2_o(rd2)
    );

    assign src_a = alu_a_pc ? pc : rd1;
    assign src_b = alu_src ? imm : rd2;

    alu i_alu (.a_i(src_a), .b_i(src_b), .ctrl_i(alu_ctrl), .y_o(alu_y), .eq_o(eq));

    load_store_unit i_lsu (
        .addr_i(alu_y), .store_data_i(rd2), .mem_rdata_i(dmem_rdata_i),
        .mem_type_i(mem_type), .mem_sign_i(mem_sign), .mem_write_i(dmem_we_o),
        .mem_wdata_o(dmem_wdata_o), .load_data_o(load_data), .mem_wstrb_o(dmem_wstrb_o)
    );

    assign pc_plus4    = pc + XLEN'(4);
    assign pc_plus_imm = pc + imm;              // Branch, JAL and AUIPC target
    assign pc_next     = jalr_pc_src ? {alu_y[XLEN-1:1], 1'b0} :
                         pc_src      ? pc_plus_imm : pc_plus4;

    always_comb
    begin
        case (result_src)
            res_mem:         result = load_data;
            res_pc_plus4:    result = pc_plus4;
            res_pc_plus_imm: result = pc_plus_imm;
            default:         result = alu_y;
        endcase
    end

    assign reg_we      = reg_write & run;
    assign dmem_we_o   = mem_write & run;
    assign imem_addr_o = pc;
    assign dmem_addr_o = alu_y;
    assign wb_valid_o  = reg_we && (imem_data_i[11:7] != '0);   // x0 writes are not traced
    assign wb_addr_o   = imem_data_i[11:7];
    assign wb_data_o   = result;

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN   = 32;                 // Data and address width
    localparam int REG_AW = 5;                  // Register index width

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_auipc  = 7'b0010111,
        opc_lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [1:0] {
        aluop_add    = 2'b00,                   // Address arithmetic
        aluop_branch = 2'b01,                   // Compare for branches
        aluop_arith  = 2'b10,                   // R-type and I-type math
        aluop_pass_b = 2'b11                    // LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        alu_add    = 3'b000,
        alu_sub    = 3'b001,
        alu_and    = 3'b010,
        alu_or     = 3'b011,
        alu_xor    = 3'b100,
        alu_slt    = 3'b101,
        alu_pass_b = 3'b110
    } alu_ctrl_e;

    typedef enum logic [2:0] {
        imm_itype = 3'b000,
        imm_stype = 3'b001,
        imm_btype = 3'b010,
        imm_jtype = 3'b011,
        imm_utype = 3'b100
    } imm_type_e;

    typedef enum logic [1:0] {
        res_alu         = 2'b00,
        res_mem         = 2'b01,
        res_pc_plus4    = 2'b10,                // Link value for jumps
        res_pc_plus_imm = 2'b11                 // AUIPC
    } result_sel_e;

endpackage

// ==== tb/rv_core_checker.sv ====
`timescale 1ns/1ps

module rv_core_checker (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       dmem_we_i,
    input  logic [3:0]                 dmem_wstrb_i,
    input  logic                       wb_valid_i,
    input  logic [rv_pkg::REG_AW-1:0]  wb_addr_i
);
    int fail_count;                             // Sampled at the end of the run

    initial
        fail_count = 0;

    // The core stays quiet while reset is low
    a_quiet_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> (!dmem_we_i && !wb_valid_i))
    else
    begin
        $error("store or retire strobe while reset is asserted");
        fail_count++;
    end

    // Run flag is still clear in the first cycle after release
    a_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> (!dmem_we_i && !wb_valid_i))
    else
    begin
        $error("store or retire strobe in the first cycle after reset");
        fail_count++;
    end

    a_no_x0_trace: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_i |-> (wb_addr_i != '0))
    else
    begin
        $error("retire strobe for register x0");
        fail_count++;
    end

    a_strobe_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !dmem_we_i |-> (dmem_wstrb_i == 4'b0000))
    else
    begin
        $error("byte strobes set without a store");
        fail_count++;
    end

endmodule

bind rv_core rv_core_checker i_checker (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .dmem_we_i(dmem_we_o),
    .dmem_wstrb_i(dmem_wstrb_o),
    .wb_valid_i(wb_valid_o),
    .wb_addr_i(wb_addr_o)
);

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int              NUM_REGS        = 32;
    localparam logic [XLEN-1:0] RESET_PC        = 32'h0000_0200;
    localparam logic [XLEN-1:0] DATA_BASE       = 32'h0000_0400;    // 64-word data area
    localparam int              IMEM_WORDS      = 256;
    localparam int              DMEM_WORDS      = 64;
    localparam int              NUM_TESTS       = 4;
    localparam int              TEST_LEN        = 400;              // Instructions per test
    localparam int              RESET_CYCLES    = 3;
    localparam int              WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + 1)
                                                  + NUM_TESTS * TEST_LEN + 10;

    typedef enum int {
        k_add, k_sub, k_and, k_or, k_xor, k_slt,
        k_addi, k_andi, k_ori, k_xori, k_slti,
        k_lw, k_lb, k_lbu, k_sw, k_sb,
        k_beq, k_bne, k_jal, k_jalr, k_lui, k_auipc, k_nop
    } instr_kind_e;

    localparam int NUM_KINDS = 23;

    logic              clk_i;
    logic              arst_n_i;
    logic [XLEN-1:0]   imem_addr_o;
    logic [XLEN-1:0]   imem_data_i;
    logic [XLEN-1:0]   dmem_addr_o;
    logic [XLEN-1:0]   dmem_wdata_o;
    logic [3:0]        dmem_wstrb_o;
    logic              dmem_we_o;
    logic [XLEN-1:0]   dmem_rdata_i;
    logic              wb_valid_o;
    logic [REG_AW-1:0] wb_addr_o;
    logic [XLEN-1:0]   wb_data_o;

    logic [31:0]       imem [IMEM_WORDS];
    logic [XLEN-1:0]   dmem [DMEM_WORDS];

    // Program as generated for the reference model
    instr_kind_e       p_kind [IMEM_WORDS];
    logic [4:0]        p_rd   [IMEM_WORDS];
    logic [4:0]        p_rs1  [IMEM_WORDS];
    logic [4:0]        p_rs2  [IMEM_WORDS];
    logic [XLEN-1:0]   p_imm  [IMEM_WORDS];

    logic [XLEN-1:0]   m_regs [32];
    logic [XLEN-1:0]   m_dmem [DMEM_WORDS];
    logic [XLEN-1:0]   m_pc;

    int                errors;
    int                checks;

    rv_core #(
        .NUM_REGS(NUM_REGS),
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .imem_addr_o(imem_addr_o),
        .imem_data_i(imem_data_i),
        .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o),
        .dmem_wstrb_o(dmem_wstrb_o),
        .dmem_we_o(dmem_we_o),
        .dmem_rdata_i(dmem_rdata_i),
        .wb_valid_o(wb_valid_o),
        .wb_addr_o(wb_addr_o),
        .wb_data_o(wb_data_o)
    );

    always #2 clk_i = ~clk_i;                   // 4 ns period

    assign imem_data_i  = imem[imem_addr_o[9:2]];    // Asynchronous reads
    assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

    always @(posedge clk_i)
    begin : dmem_write
        int lane;
        if (dmem_we_o)
        begin
            for (lane = 0; lane < 4; lane++)
                if (dmem_wstrb_o[lane])
                    dmem[dmem_addr_o[7:2]][8*lane +: 8] <= dmem_wdata_o[8*lane +: 8];
        end
    end

    function automatic logic [31:0] encode_instr(input instr_kind_e k, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                                 input logic [31:0] imm);
        case (k)
            k_add:   return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            k_sub:   return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            k_and:   return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            k_or:    return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            k_xor:   return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            k_slt:   return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
            k_addi:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            k_andi:  return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            k_ori:   return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            k_xori:  return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            k_slti:  return {imm[11:0], rs1, 3'b010, rd, 7'b0010011};
            k_lw:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            k_lb:    return {imm[11:0], rs1, 3'b000, rd, 7'b0000011};
            k_lbu:   return {imm[11:0], rs1, 3'b100, rd, 7'b0000011};
            k_sw:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            k_sb:    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b0100011};
            k_beq:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            k_bne:   return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            k_jal:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            k_jalr:  return {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
            k_lui:   return {imm[31:12], rd, 7'b0110111};
            k_auipc: return {imm[31:12], rd, 7'b0010111};
            default: return {imm[11:0], rs1, 3'b000, rd, 7'b0001111};  // FENCE is not decoded
        endcase
    endfunction

    task automatic gen_program();
        int          i;
        int          tgt;
        instr_kind_e k;
        logic [31:0] r;
        for (i = 0; i < IMEM_WORDS; i++)
        begin
            k          = instr_kind_e'($urandom_range(0, NUM_KINDS - 1));
            k          = (i == IMEM_WORDS - 1) ? k_jal : k;   // Last word jumps back
            r          = $urandom;
            tgt        = (i + 1 + $urandom_range(0, IMEM_WORDS - 2)) % IMEM_WORDS;
            p_rd[i]    = 5'($urandom_range(0, 31));
            p_rs1[i]   = 5'($urandom_range(0, 31));
            p_rs2[i]   = r[0] ? p_rs1[i] : 5'($urandom_range(0, 31));
            p_imm[i]   = {{20{r[11]}}, r[11:0]};
            case (k)
                k_lw, k_sw:
                    p_imm[i] = DATA_BASE + 4 * $urandom_range(0, DMEM_WORDS - 1);
                k_lb, k_lbu, k_sb:
                    p_imm[i] = DATA_BASE + $urandom_range(0, 4 * DMEM_WORDS - 1);
                k_beq, k_bne, k_jal:
                    p_imm[i] = 32'((tgt - i) * 4);
                k_jalr:
                    p_imm[i] = 32'(tgt * 4 + $urandom_range(0, 1));   // Bit 0 is dropped
                k_lui, k_auipc:
                    p_imm[i] = {r[31:12], 12'b0};
                default:
                    p_imm[i] = p_imm[i];
            endcase
            if (k inside {k_lw, k_lb, k_lbu, k_sw, k_sb, k_jalr})
                p_rs1[i] = 5'd0;                  // x0-based addresses
            p_kind[i] = k;
            imem[i]   = encode_instr(k, p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
        end
    endtask

    task automatic load_test(input int t);
        int w;
        for (w = 0; w < DMEM_WORDS; w++)
        begin
            dmem[w]   = (32'h9E37_79B1 * (w + 1)) ^ (32'(t) << 24);
            m_dmem[w] = dmem[w];
        end
        for (w = 0; w < 32; w++)
            m_regs[w] = '0;
        m_pc = RESET_PC;
        gen_program();
    endtask

    task automatic report_mismatch(input string what, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        errors++;
        $display("** Error @ %0t: %s at pc %h: got %h, expected %h", $time, what, m_pc, got, exp);
    endtask

    task automatic check_pc(input logic [XLEN-1:0] exp_pc);
        checks++;
        if (imem_addr_o !== exp_pc)
            report_mismatch("imem_addr_o", imem_addr_o, exp_pc);
    endtask

    task automatic check_wb(input logic exp_valid, input logic [REG_AW-1:0] exp_addr,
                            input logic [XLEN-1:0] exp_data);
        checks++;
        if (wb_valid_o !== exp_valid)
            report_mismatch("wb_valid_o", XLEN'(wb_valid_o), XLEN'(exp_valid));
        else if (exp_valid && wb_addr_o !== exp_addr)
            report_mismatch("wb_addr_o", XLEN'(wb_addr_o), XLEN'(exp_addr));
        else if (exp_valid && wb_data_o !== exp_data)
            report_mismatch("wb_data_o", wb_data_o, exp_data);
    endtask

    task automatic check_store(input logic exp_we, input logic [XLEN-1:0] exp_addr,
                               input logic [XLEN-1:0] exp_data, input logic [3:0] exp_strb);
        checks++;
        if (dmem_we_o !== exp_we)
            report_mismatch("dmem_we_o", XLEN'(dmem_we_o), XLEN'(exp_we));
        else if (exp_we && dmem_addr_o !== exp_addr)
            report_mismatch("dmem_addr_o", dmem_addr_o, exp_addr);
        else if (exp_we && dmem_wdata_o !== exp_data)
            report_mismatch("dmem_wdata_o", dmem_wdata_o, exp_data);
        else if (exp_we && dmem_wstrb_o !== exp_strb)
            report_mismatch("dmem_wstrb_o", XLEN'(dmem_wstrb_o), XLEN'(exp_strb));
    endtask

    // Reference model retires the instruction at m_pc and checks the DUT against it
    task automatic step_and_check();
        int              i;
        int              lane;
        logic [XLEN-1:0] a, b, res, nxt, addr, wdata;
        logic [7:0]      ld_b;
        logic [3:0]      strb;
        logic            we, st;
        i     = int'(m_pc[9:2]);
        a     = m_regs[p_rs1[i]];
        b     = m_regs[p_rs2[i]];
        addr  = a + p_imm[i];
        nxt   = m_pc + 32'd4;
        res   = '0;
        wdata = '0;
        strb  = '0;
        we    = 1'b1;
        st    = 1'b0;
        ld_b  = 8'(m_dmem[addr[7:2]] >> (8 * addr[1:0]));
        case (p_kind[i])
            k_add:   res = a + b;
            k_sub:   res = a - b;
            k_and:   res = a & b;
            k_or:    res = a | b;
            k_xor:   res = a ^ b;
            k_slt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            k_addi:  res = a + p_imm[i];
            k_andi:  res = a & p_imm[i];
            k_ori:   res = a | p_imm[i];
            k_xori:  res = a ^ p_imm[i];
            k_slti:  res = ($signed(a) < $signed(p_imm[i])) ? 32'd1 : 32'd0;
            k_lw:    res = m_dmem[addr[7:2]];
            k_lb:    res = {{24{ld_b[7]}}, ld_b};
            k_lbu:   res = {24'b0, ld_b};
            k_sw:
            begin
                we    = 1'b0;
                st    = 1'b1;
                wdata = b;
                strb  = 4'b1111;
            end
            k_sb:
            begin
                we = 1'b0;
                st = 1'b1;
                for (lane = 0; lane < 4; lane++)
                begin
                    wdata[8*lane +: 8] = b[7:0];         // Byte on all lanes
                    strb[lane]         = (addr[1:0] == 2'(lane));
                end
            end
            k_beq:
            begin
                we = 1'b0;
                if (a == b)
                    nxt = m_pc + p_imm[i];
            end
            k_bne:
            begin
                we = 1'b0;
                if (a != b)
                    nxt = m_pc + p_imm[i];
            end
            k_jal:
            begin
                res = m_pc + 32'd4;
                nxt = m_pc + p_imm[i];
            end
            k_jalr:
            begin
                res = m_pc + 32'd4;
                nxt = addr & ~32'd1;
            end
            k_lui:   res = p_imm[i];
            k_auipc: res = m_pc + p_imm[i];
            default: we = 1'b0;                      // Undecoded opcode
        endcase
        if (p_rd[i] == 5'd0)
            we = 1'b0;
        check_pc(m_pc);
        check_wb(we, p_rd[i], res);
        check_store(st, addr, wdata, strb);
        if (we)
            m_regs[p_rd[i]] = res;
        for (lane = 0; lane < 4; lane++)
            if (st && strb[lane])
                m_dmem[addr[7:2]][8*lane +: 8] = wdata[8*lane +: 8];
        m_pc = nxt;
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        int t;
        int k;
        int err_before;
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        errors   = 0;
        checks   = 0;
        void'($urandom(26435));
        for (k = 0; k < IMEM_WORDS; k++)
            imem[k] = 32'h0000_0013;                 // ADDI x0, x0, 0
        for (k = 0; k < DMEM_WORDS; k++)
            dmem[k] = '0;
        for (t = 0; t < NUM_TESTS; t++)
        begin
            err_before = errors;
            arst_n_i <= 1'b0;                        // Lands mid-run from the second test on
            @(negedge clk_i);
            load_test(t);
            repeat (RESET_CYCLES) @(posedge clk_i);
            arst_n_i <= 1'b1;
            @(posedge clk_i);                        // Run flag sets here
            for (k = 0; k < TEST_LEN; k++)
            begin
                @(negedge clk_i);
                step_and_check();
                @(posedge clk_i);
            end
            $display("Test %0d: %0d instructions retired, %0d errors",
                     t, TEST_LEN, errors - err_before);
        end
        @(negedge clk_i);
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 NUM_TESTS, checks, errors, i_dut.i_checker.fail_count);
        if (errors == 0 && i_dut.i_checker.fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
